// File: verilog/seq_pkg.sv
package seq_pkg;

    // ******************************
    // Word geometry
    // ******************************
    localparam int SEQ_W         = 64;
    localparam int BASES_PER_SEQ = 31;

    // The complement of a base is its bitwise inverse.
    typedef enum logic [1:0] {
        BASE_A = 2'd0,
        BASE_C = 2'd1,
        BASE_G = 2'd2,
        BASE_T = 2'd3
    } base_t;

    // ******************************
    // Two views of one word
    // ******************************
    typedef struct packed {
        logic [2*BASES_PER_SEQ-1:0] payload;  // Bases, raw bits.
        logic                       strand;   // 1 = reverse strand.
        logic                       valid;    // Bit 0.
    } seq_fields_t;

    typedef struct packed {
        base_t [BASES_PER_SEQ-1:0] base;
        logic                      strand;
        logic                      valid;
    } seq_bases_t;

    typedef union packed {
        seq_fields_t fields;
        seq_bases_t  bases;
    } seq_word_u;

endpackage

// File: verilog/stream_pkg.sv
package stream_pkg;

    // ******************************
    // Job quad shape
    // ******************************

    // Lanes per job quad; lane 0 sits in the low word of a quad bus.
    localparam int QUAD_LANES_DEFAULT = 4;

endpackage

// File: verilog/job_split.sv
`timescale 1ns/1ps

module job_split #(
    parameter int LANES = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              in_valid,
    input  logic                              in_end_of_job,
    input  seq_pkg::seq_word_u [LANES-1:0]    in_seq_quad,
    output logic                              in_ready,

    output logic                              split_valid,
    output logic                              split_end_of_job,
    output seq_pkg::seq_word_u                split_seq,
    input  logic                              split_ready
);
    import seq_pkg::*;

    localparam int LANE_W = $clog2(LANES);

    seq_word_u [LANES-1:0] quad_q;
    logic                  eoj_q;
    logic [LANES-1:0]      pending;       // Lanes still to be sent.
    logic [LANES-1:0]      pending_rest;
    logic [LANES-1:0]      lane_valid;
    logic [LANE_W-1:0]     lane_sel;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_valid[i] = in_seq_quad[i].fields.valid;
        end
    end

    // Lowest pending lane wins.
    always_comb begin
        lane_sel = '0;
        for (int i = LANES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                lane_sel = LANE_W'(i);
            end
        end
    end

    assign pending_rest = pending & (pending - 1'b1);  // Drops the lowest set bit.

    assign in_ready         = (pending == '0);
    assign split_valid      = |pending;
    assign split_seq        = quad_q[lane_sel];
    assign split_end_of_job = eoj_q && (pending_rest == '0);

    // ******************************
    // Lane bookkeeping
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
            eoj_q   <= 1'b0;
        end else if (in_valid && in_ready) begin
            pending <= lane_valid;
            eoj_q   <= in_end_of_job;
        end else if (split_valid && split_ready) begin
            pending <= pending_rest;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            quad_q <= in_seq_quad;
        end
    end

endmodule

// File: verilog/seq_canon.sv
`timescale 1ns/1ps

module seq_canon (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               split_valid,
    input  logic               split_end_of_job,
    input  seq_pkg::seq_word_u split_seq,
    output logic               split_ready,

    output logic               canon_valid,
    output logic               canon_end_of_job,
    output seq_pkg::seq_word_u canon_seq,
    input  logic               canon_ready
);
    import seq_pkg::*;

    seq_word_u canon_d;

    // ******************************
    // Reverse complement
    // ******************************
    always_comb begin
        canon_d = split_seq;
        if (split_seq.bases.strand) begin
            for (int i = 0; i < BASES_PER_SEQ; i++) begin
                canon_d.bases.base[i] = base_t'(~split_seq.bases.base[BASES_PER_SEQ-1-i]);
            end
            canon_d.bases.strand = 1'b0;  // Now forward.
        end
    end

    // Register frees up when empty or drained this cycle.
    assign split_ready = !canon_valid || canon_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            canon_valid <= 1'b0;
        end else if (split_ready) begin
            canon_valid <= split_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (split_valid && split_ready) begin
            canon_seq        <= canon_d;
            canon_end_of_job <= split_end_of_job;
        end
    end

endmodule

// File: verilog/job_concat.sv
`timescale 1ns/1ps

module job_concat #(
    parameter int LANES = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           canon_valid,
    input  logic                           canon_end_of_job,
    input  seq_pkg::seq_word_u             canon_seq,
    output logic                           canon_ready,

    output logic                           out_valid,
    output logic                           out_end_of_job,
    output seq_pkg::seq_word_u [LANES-1:0] out_seq_quad,
    input  logic                           out_ready
);
    import seq_pkg::*;

    localparam int CNT_W = $clog2(LANES);

    typedef enum logic {
        ST_COLLECT = 1'b0,
        ST_OUTPUT  = 1'b1
    } state_t;

    state_t                   state;
    logic [CNT_W-1:0]         lane_cnt;
    logic [LANES*SEQ_W-1:0]   quad_q;  // Unused lanes stay zero.
    logic                     last_lane;

    assign last_lane    = (lane_cnt == CNT_W'(LANES - 1));
    assign canon_ready  = (state == ST_COLLECT);
    assign out_valid    = (state == ST_OUTPUT);
    assign out_seq_quad = quad_q;

    // ******************************
    // Collect / output FSM
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= ST_COLLECT;
            lane_cnt       <= '0;
            quad_q         <= '0;
            out_end_of_job <= 1'b0;
        end else begin
            case (state)
                ST_COLLECT: begin
                    if (canon_valid) begin
                        quad_q[lane_cnt*SEQ_W +: SEQ_W] <= canon_seq;
                        lane_cnt       <= lane_cnt + 1'b1;
                        out_end_of_job <= canon_end_of_job;
                        if (last_lane || canon_end_of_job) begin
                            state <= ST_OUTPUT;  // Full quad or flush.
                        end
                    end
                end
                ST_OUTPUT: begin
                    if (out_ready) begin
                        quad_q   <= '0;
                        lane_cnt <= '0;
                        state    <= ST_COLLECT;
                    end
                end
                default: state <= ST_COLLECT;
            endcase
        end
    end

endmodule

// File: verilog/seq_pack_top.sv
`timescale 1ns/1ps

module seq_pack_top #(
    parameter int LANES = stream_pkg::QUAD_LANES_DEFAULT
) (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           in_valid,
    input  logic                           in_end_of_job,
    input  seq_pkg::seq_word_u [LANES-1:0] in_seq_quad,
    output logic                           in_ready,

    output logic                           out_valid,
    output logic                           out_end_of_job,
    output seq_pkg::seq_word_u [LANES-1:0] out_seq_quad,
    input  logic                           out_ready
);
    import seq_pkg::*;

    logic      split_valid;
    logic      split_end_of_job;
    seq_word_u split_seq;
    logic      split_ready;

    logic      canon_valid;
    logic      canon_end_of_job;
    seq_word_u canon_seq;
    logic      canon_ready;

    // ******************************
    // Split -> canon -> concat
    // ******************************
    job_split #(
        .LANES(LANES)
    ) job_split_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_end_of_job    (in_end_of_job),
        .in_seq_quad      (in_seq_quad),
        .in_ready         (in_ready),
        .split_valid      (split_valid),
        .split_end_of_job (split_end_of_job),
        .split_seq        (split_seq),
        .split_ready      (split_ready)
    );

    seq_canon seq_canon_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .split_valid      (split_valid),
        .split_end_of_job (split_end_of_job),
        .split_seq        (split_seq),
        .split_ready      (split_ready),
        .canon_valid      (canon_valid),
        .canon_end_of_job (canon_end_of_job),
        .canon_seq        (canon_seq),
        .canon_ready      (canon_ready)
    );

    job_concat #(
        .LANES(LANES)
    ) job_concat_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .canon_valid      (canon_valid),
        .canon_end_of_job (canon_end_of_job),
        .canon_seq        (canon_seq),
        .canon_ready      (canon_ready),
        .out_valid        (out_valid),
        .out_end_of_job   (out_end_of_job),
        .out_seq_quad     (out_seq_quad),
        .out_ready        (out_ready)
    );

endmodule

// File: verification/seq_pack_tests.svh
`ifndef SEQ_PACK_TESTS_SVH
`define SEQ_PACK_TESTS_SVH

// ******************************
// Directed tests
// ******************************
task automatic test_reset();
    int wait_cnt;
    test_errors = 0;
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    check_level(out_valid, 1'b0, "out_valid after reset");
    wait_cnt = 0;
    while (!in_ready && wait_cnt < 1) begin
        @(negedge clk);
        wait_cnt++;
    end
    check_level(in_ready, 1'b1, "in_ready after reset");
    group.delete();
    exp_q.delete();
    exp_eoj_q.delete();
    end_test("reset");
endtask

task automatic test_dense_job();
    quad_t q;
    start_test();
    fork
        begin
            for (int n = 0; n < 4; n++) begin
                for (int i = 0; i < LANES; i++) begin
                    q[i] = rand_word(1'b0, 1'b1);
                end
                send_quad(q, n == 3);
            end
            drive_done = 1'b1;
        end
        collect(1'b0);
    join
    end_test("dense_job");
endtask

task automatic test_bubbles();
    quad_t q;
    start_test();
    fork
        begin
            for (int n = 0; n < 6; n++) begin
                for (int i = 0; i < LANES; i++) begin
                    q[i] = rand_word(rand_bits(1) != 0, rand_bits(1) != 0);
                end
                if (n == 5) begin
                    q[0].fields.valid = 1'b1;  // End-of-job quad is never empty.
                end
                send_quad(q, n == 5);
            end
            drive_done = 1'b1;
        end
        collect(1'b0);
    join
    end_test("bubbles");
endtask

task automatic test_partial_flush();
    quad_t q;
    start_test();
    fork
        begin
            for (int n = 0; n < 3; n++) begin
                for (int i = 0; i < LANES; i++) begin
                    q[i] = rand_word(1'b0, (n == 0) || (n == 1 && i < 2) || (n == 2 && i > 0));
                end
                send_quad(q, n != 0);  // Second job begins with quad 2.
            end
            drive_done = 1'b1;
        end
        collect(1'b0);
    join
    end_test("partial_flush");
endtask

task automatic test_reverse_strand();
    logic [61:0] pat_in [4];
    logic [61:0] pat_out [4];
    quad_t       kq;
    quad_t       ke;
    quad_t       q;
    pat_in  = '{62'h0, 62'h3fff_ffff_ffff_ffff, 62'h1, 62'h2aaa_aaaa_aaaa_aaaa};
    pat_out = '{62'h3fff_ffff_ffff_ffff, 62'h0, 62'h2fff_ffff_ffff_ffff,
                62'h1555_5555_5555_5555};
    for (int i = 0; i < LANES; i++) begin
        kq[i] = mk_word(pat_in[i % 4], 1'b1, 1'b1);
        ke[i] = mk_word(pat_out[i % 4], 1'b0, 1'b1);
    end
    start_test();
    fork
        begin
            exp_q.push_back(ke);  // Hand-made results for known patterns.
            exp_eoj_q.push_back(1'b1);
            drive_quad(kq, 1'b1);
            for (int n = 0; n < 3; n++) begin
                for (int i = 0; i < LANES; i++) begin
                    q[i] = rand_word(1'b1, 1'b1);
                end
                send_quad(q, n == 2);
            end
            drive_done = 1'b1;
        end
        collect(1'b0);
    join
    end_test("reverse_strand");
endtask

task automatic test_backpressure();
    quad_t qs[$];
    logic  eojs[$];
    quad_t q;
    logic  eoj;
    for (int n = 0; n < 40; n++) begin
        for (int i = 0; i < LANES; i++) begin
            q[i] = rand_word(rand_bits(1) != 0, rand_bits(2) != 0);
        end
        eoj = (n == 39) || (rand_bits(3) == 0);
        if (eoj) begin
            q[0].fields.valid = 1'b1;
        end
        qs.push_back(q);
        eojs.push_back(eoj);
    end
    start_test();
    fork
        begin
            foreach (qs[n]) begin
                send_quad(qs[n], eojs[n]);
            end
            drive_done = 1'b1;
        end
        collect(1'b1);
    join
    end_test("backpressure");
endtask

`endif

// File: verification/seq_pack_tb.sv
`timescale 1ns/1ps

module seq_pack_tb;
    import seq_pkg::*;
    import stream_pkg::*;

    localparam int LANES   = QUAD_LANES_DEFAULT;
    localparam int TIMEOUT = 200;  // Cycles allowed per wait loop.

    typedef seq_word_u [LANES-1:0] quad_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_end_of_job;
    quad_t       in_seq_quad;
    logic        in_ready;
    logic        out_valid;
    logic        out_end_of_job;
    quad_t       out_seq_quad;
    logic        out_ready;

    logic [31:0] lfsr = 32'h4a0e;
    quad_t       exp_q[$];
    logic        exp_eoj_q[$];
    seq_word_u   group[$];  // Canonical words not yet packed.
    bit          drive_done;
    int          errors;
    int          test_errors;
    int          checks;
    int          tests;

    seq_pack_top #(
        .LANES(LANES)
    ) seq_pack_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_end_of_job  (in_end_of_job),
        .in_seq_quad    (in_seq_quad),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_end_of_job (out_end_of_job),
        .out_seq_quad   (out_seq_quad),
        .out_ready      (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ******************************
    // Stimulus helpers
    // ******************************
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic seq_word_u mk_word(input logic [61:0] payload, input logic strand,
                                          input logic valid);
        seq_word_u w;
        w.fields.payload = payload;
        w.fields.strand  = strand;
        w.fields.valid   = valid;
        return w;
    endfunction

    function automatic seq_word_u rand_word(input logic strand, input logic valid);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand_bits(30);
        lo = rand_bits(32);
        return mk_word({hi[29:0], lo}, strand, valid);
    endfunction

    // ******************************
    // Reference model
    // ******************************
    function automatic seq_word_u canon_ref(input seq_word_u w);
        seq_word_u r;
        r = w;
        if (w.fields.strand) begin
            for (int i = 0; i < BASES_PER_SEQ; i++) begin
                r.fields.payload[2*i +: 2] = ~w.fields.payload[2*(BASES_PER_SEQ-1-i) +: 2];
            end
            r.fields.strand = 1'b0;
        end
        return r;
    endfunction

    task automatic model_push(input seq_word_u w, input logic eoj);
        quad_t q;
        group.push_back(canon_ref(w));
        if (group.size() == LANES || eoj) begin
            q = '0;  // Unused lanes read as zero.
            foreach (group[i]) begin
                q[i] = group[i];
            end
            exp_q.push_back(q);
            exp_eoj_q.push_back(eoj);
            group.delete();
        end
    endtask

    // ******************************
    // Compare tasks
    // ******************************
    task automatic check_quad(input quad_t got, input quad_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_eoj(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
            test_errors++;
        end
    endtask

    // ******************************
    // Driver and collector
    // ******************************
    task automatic drive_quad(input quad_t q, input logic eoj);
        int wait_cnt;
        in_valid      = 1'b1;
        in_end_of_job = eoj;
        in_seq_quad   = q;
        wait_cnt      = 0;
        while (!in_ready && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!in_ready) begin
            $display("Timeout at %0t: in_ready stayed low for %0d cycles", $time, TIMEOUT);
            test_errors++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_quad(input quad_t q, input logic eoj);
        int last;
        last = -1;
        for (int i = 0; i < LANES; i++) begin
            if (q[i].fields.valid) begin
                last = i;
            end
        end
        for (int i = 0; i < LANES; i++) begin
            if (q[i].fields.valid) begin
                model_push(q[i], eoj && (i == last));  // Flag rides on the last word.
            end
        end
        drive_quad(q, eoj);
    endtask

    task automatic collect(input bit bp);
        int    idle;
        bit    held;
        quad_t held_quad;
        idle = 0;
        held = 1'b0;
        while (!(drive_done && exp_q.size() == 0) && idle < TIMEOUT) begin
            @(negedge clk);
            out_ready = bp ? (rand_bits(2) != 0) : 1'b1;
            idle++;
            if (out_valid && held) begin
                check_quad(out_seq_quad, held_quad, "stalled quad");
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: output quad arrived with none expected", $time);
                    test_errors++;
                end else begin
                    check_quad(out_seq_quad, exp_q.pop_front(), "output quad");
                    check_eoj(out_end_of_job, exp_eoj_q.pop_front(), "end of job");
                end
                idle = 0;
                held = 1'b0;
            end else if (out_valid) begin
                held      = 1'b1;
                held_quad = out_seq_quad;
            end
        end
        if (idle >= TIMEOUT) begin
            $display("Timeout at %0t: no output quad for %0d cycles", $time, TIMEOUT);
            test_errors++;
        end
        out_ready = 1'b1;
    endtask

    task automatic start_test();
        test_errors = 0;
        drive_done  = 1'b0;
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        tests++;
        errors += test_errors;
        $display("Test %s finished with %0d errors", name, test_errors);
    endtask

    `include "seq_pack_tests.svh"

    initial begin
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_end_of_job = 1'b0;
        in_seq_quad   = '0;
        out_ready     = 1'b1;
        drive_done    = 1'b0;
        errors        = 0;
        test_errors   = 0;
        checks        = 0;
        tests         = 0;
        test_reset();
        test_dense_job();
        test_bubbles();
        test_partial_flush();
        test_reverse_strand();
        test_backpressure();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+verification
verilog/seq_pkg.sv
verilog/stream_pkg.sv
verilog/job_split.sv
verilog/seq_canon.sv
verilog/job_concat.sv
verilog/seq_pack_top.sv
verification/seq_pack_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= seq_pack_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
